/* fetch_pkg.sv */
package fetch_pkg;

    localparam int INSTR_W     = 32;
    localparam int LINE_ADDR_W = 29;

    typedef logic [INSTR_W-1:0]     fetch_instr_t;
    typedef logic [LINE_ADDR_W-1:0] fetch_line_addr_t;

    // pc split into line, word in line and byte
    typedef struct packed {
        fetch_line_addr_t line;
        logic             word;
        logic [1:0]       byte_ofs;
    } fetch_pc_fields_t;

    typedef union packed {
        logic [31:0]      raw;
        fetch_pc_fields_t fields;
    } fetch_pc_t;

    // word 0 is the lower address
    typedef fetch_instr_t [1:0] fetch_line_t;

    typedef struct packed {
        fetch_pc_t pc;
        logic      req;
    } fetch_req_t;

    typedef struct packed {
        logic         ack;
        fetch_instr_t instr;
    } fetch_rsp_t;

    // finished line on its way into the cache
    typedef struct packed {
        logic             valid;
        fetch_line_addr_t addr;
        fetch_line_t      data;
    } fetch_fill_t;

endpackage

/* wb_pkg.sv */
package wb_pkg;

    localparam int WB_ADR_W = 29;
    localparam int WB_DAT_W = 64;

    // master to slave addressed by line
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
    } wb_m2s_t;

    // slave to master with one whole line per ack
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_s2m_t;

endpackage

/* fetch_line_cache.sv */
`timescale 1ns/100ps

module fetch_line_cache #(
    parameter int CACHE_DEPTH    = 4,
    parameter int PREFETCH_DEPTH = 2
) (
    input  logic                                             clk,
    input  logic                                             reset,
    input  fetch_pkg::fetch_req_t                            req,
    output fetch_pkg::fetch_rsp_t                            rsp,
    input  fetch_pkg::fetch_fill_t                           fill,
    input  fetch_pkg::fetch_line_addr_t [PREFETCH_DEPTH-1:0] probe_addr,
    output logic [PREFETCH_DEPTH-1:0]                        probe_found,
    output logic                                             miss,
    output fetch_pkg::fetch_line_addr_t                      miss_addr
);

    import fetch_pkg::*;

    localparam int PTR_W = (CACHE_DEPTH > 1) ? $clog2(CACHE_DEPTH) : 1;

    fetch_line_addr_t       tag  [CACHE_DEPTH];
    fetch_line_t            data [CACHE_DEPTH];
    logic [CACHE_DEPTH-1:0] valid;
    logic [PTR_W-1:0]       victim;

    fetch_line_addr_t       demand_line;
    logic                   hit;
    fetch_line_t            hit_line;
    logic                   ack_q;
    fetch_instr_t           instr_q;

    assign demand_line = req.pc.fields.line;

    // demand tag compare over all entries at once
    always_comb begin
        hit      = 1'b0;
        hit_line = '0;
        for (int i = 0; i < CACHE_DEPTH; i++) begin
            if (valid[i] && tag[i] == demand_line) begin
                hit      = 1'b1;
                hit_line = data[i];
            end
        end
    end

    // prefetch probes
    always_comb begin
        for (int p = 0; p < PREFETCH_DEPTH; p++) begin
            probe_found[p] = 1'b0;
            for (int i = 0; i < CACHE_DEPTH; i++) begin
                if (valid[i] && tag[i] == probe_addr[p]) begin
                    probe_found[p] = 1'b1;
                end
            end
        end
    end

    // request still up in its ack cycle is already served
    assign miss      = req.req & ~hit & ~ack_q;
    assign miss_addr = demand_line;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req.req & hit & ~ack_q;
        end
    end

    always_ff @(posedge clk) begin
        instr_q <= hit_line[req.pc.fields.word];
    end

    assign rsp = '{ack: ack_q, instr: instr_q};

    // round-robin replacement
    always_ff @(posedge clk) begin
        if (reset) begin
            valid  <= '0;
            victim <= '0;
        end else if (fill.valid) begin
            valid[victim] <= 1'b1;
            if (victim == PTR_W'(CACHE_DEPTH - 1)) begin
                victim <= '0;
            end else begin
                victim <= victim + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill.valid) begin
            tag[victim]  <= fill.addr;
            data[victim] <= fill.data;
        end
    end

endmodule

/* fetch_mem_access.sv */
`timescale 1ns/100ps

module fetch_mem_access (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  fetch_pkg::fetch_line_addr_t start_addr,
    output logic                        busy,
    output fetch_pkg::fetch_line_addr_t busy_addr,
    output wb_pkg::wb_m2s_t             wb_out,
    input  wb_pkg::wb_s2m_t             wb_in,
    output fetch_pkg::fetch_fill_t      fill
);

    import fetch_pkg::*;

    typedef enum logic {
        IDLE,
        READING
    } state_t;

    state_t           state;
    fetch_line_addr_t adr_q;
    logic             fill_valid;
    fetch_line_t      fill_data;
    logic             take;
    logic             done;

    // busy runs through the fill cycle
    assign busy = (state == READING) | fill_valid;
    assign take = start & ~busy;
    assign done = (state == READING) & wb_in.ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        state <= READING;
                    end
                end
                READING: begin
                    if (wb_in.ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // address held for the whole bus cycle
    always_ff @(posedge clk) begin
        if (take) begin
            adr_q <= start_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            fill_data <= wb_in.dat;
        end
    end

    assign busy_addr = adr_q;

    assign wb_out = '{cyc: (state == READING), stb: (state == READING), we: 1'b0, adr: adr_q};
    assign fill   = '{valid: fill_valid, addr: adr_q, data: fill_data};

endmodule

/* fetch_next_addr.sv */
`timescale 1ns/100ps

module fetch_next_addr #(
    parameter int PREFETCH_DEPTH = 2
) (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             miss,
    input  fetch_pkg::fetch_line_addr_t                      miss_addr,
    input  fetch_pkg::fetch_rsp_t                            rsp,
    input  fetch_pkg::fetch_req_t                            req,
    output fetch_pkg::fetch_line_addr_t [PREFETCH_DEPTH-1:0] probe_addr,
    input  logic [PREFETCH_DEPTH-1:0]                        probe_found,
    input  logic                                             busy,
    input  fetch_pkg::fetch_line_addr_t                      busy_addr,
    output logic                                             start,
    output fetch_pkg::fetch_line_addr_t                      start_addr
);

    import fetch_pkg::*;

    fetch_line_addr_t last_line;
    logic             last_valid;
    logic             miss_go;
    logic             pf_go;
    fetch_line_addr_t pf_addr;

    // nothing to prefetch before the first ack
    always_ff @(posedge clk) begin
        if (reset) begin
            last_valid <= 1'b0;
        end else if (rsp.ack) begin
            last_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp.ack) begin
            last_line <= req.pc.fields.line;
        end
    end

    always_comb begin
        for (int p = 0; p < PREFETCH_DEPTH; p++) begin
            probe_addr[p] = last_line + LINE_ADDR_W'(p + 1);
        end
    end

    // demand miss first unless that line is already on the bus
    assign miss_go = miss & ~(busy & (miss_addr == busy_addr));

    // lowest probe that is neither cached nor in flight
    always_comb begin
        pf_go   = 1'b0;
        pf_addr = probe_addr[0];
        for (int p = PREFETCH_DEPTH - 1; p >= 0; p--) begin
            if (last_valid && !probe_found[p] &&
                !(busy && probe_addr[p] == busy_addr)) begin
                pf_go   = 1'b1;
                pf_addr = probe_addr[p];
            end
        end
    end

    assign start      = ~busy & (miss_go | pf_go);
    assign start_addr = miss_go ? miss_addr : pf_addr;

endmodule

/* fetch_top.sv */
`timescale 1ns/100ps

module fetch_top #(
    parameter int CACHE_DEPTH    = 4,
    parameter int PREFETCH_DEPTH = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::fetch_req_t req,
    output fetch_pkg::fetch_rsp_t rsp,
    output wb_pkg::wb_m2s_t       wb_out,
    input  wb_pkg::wb_s2m_t       wb_in
);

    import fetch_pkg::*;

    fetch_fill_t                           fill;
    fetch_line_addr_t [PREFETCH_DEPTH-1:0] probe_addr;
    logic [PREFETCH_DEPTH-1:0]             probe_found;
    logic                                  miss;
    fetch_line_addr_t                      miss_addr;
    logic                                  busy;
    fetch_line_addr_t                      busy_addr;
    logic                                  start;
    fetch_line_addr_t                      start_addr;

    fetch_line_cache #(
        .CACHE_DEPTH    (CACHE_DEPTH),
        .PREFETCH_DEPTH (PREFETCH_DEPTH)
    ) u_cache (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .rsp         (rsp),
        .fill        (fill),
        .probe_addr  (probe_addr),
        .probe_found (probe_found),
        .miss        (miss),
        .miss_addr   (miss_addr)
    );

    fetch_mem_access u_mem_access (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .start_addr (start_addr),
        .busy       (busy),
        .busy_addr  (busy_addr),
        .wb_out     (wb_out),
        .wb_in      (wb_in),
        .fill       (fill)
    );

    fetch_next_addr #(
        .PREFETCH_DEPTH (PREFETCH_DEPTH)
    ) u_next_addr (
        .clk         (clk),
        .reset       (reset),
        .miss        (miss),
        .miss_addr   (miss_addr),
        .rsp         (rsp),
        .req         (req),
        .probe_addr  (probe_addr),
        .probe_found (probe_found),
        .busy        (busy),
        .busy_addr   (busy_addr),
        .start       (start),
        .start_addr  (start_addr)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // released 1 ns after an edge like all other stimulus
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* tb_inst_mem.sv */
`timescale 1ns/100ps

module tb_inst_mem (
    input  logic            clk,
    input  logic            reset,
    input  wb_pkg::wb_m2s_t wb_out,
    output wb_pkg::wb_s2m_t wb_in,
    output int              read_count
);

    import wb_pkg::*;

    logic [31:0]         lfsr      = 32'hcb00;
    logic                pending   = 1'b0;
    logic [1:0]          wait_left = 2'd0;
    logic                ack_q     = 1'b0;
    logic [WB_DAT_W-1:0] dat_q     = '0;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // word n of the image holds n ^ 5a5a0000
    function automatic logic [WB_DAT_W-1:0] line_data(input logic [WB_ADR_W-1:0] adr);
        logic [31:0] w0;
        logic [31:0] w1;
        w0 = 32'({adr, 1'b0}) ^ 32'h5a5a0000;
        w1 = 32'({adr, 1'b1}) ^ 32'h5a5a0000;
        return {w1, w0};
    endfunction

    always @(posedge clk) begin : serve
        logic [31:0] s1;
        logic [1:0]  draw;
        s1   = lfsr_next(lfsr);
        draw = {lfsr[0], s1[0]};
        if (reset) begin
            lfsr       <= 32'hcb00;
            pending    <= 1'b0;
            wait_left  <= 2'd0;
            ack_q      <= 1'b0;
            read_count <= 0;
        end else begin
            ack_q <= 1'b0;
            if (wb_out.cyc && wb_out.stb && !ack_q) begin
                // two bits of wait count per new bus cycle
                if (!pending) begin
                    lfsr <= lfsr_next(s1);
                end
                if (!pending && draw != 2'd0) begin
                    pending   <= 1'b1;
                    wait_left <= draw - 2'd1;
                end else if (pending && wait_left != 2'd0) begin
                    wait_left <= wait_left - 2'd1;
                end else begin
                    pending    <= 1'b0;
                    ack_q      <= 1'b1;
                    dat_q      <= line_data(wb_out.adr);
                    read_count <= read_count + 1;
                end
            end
        end
    end

    assign wb_in = '{ack: ack_q, dat: dat_q};

endmodule

/* tb_fetch.sv */
`timescale 1ns/100ps

module tb_fetch;

    import fetch_pkg::*;
    import wb_pkg::*;

    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 16;
    // worst miss is a prefetch in flight then the demand read with 3 wait states each
    localparam int MISS_LAT     = 24;
    // requests plus idle waits of each test in units of one miss
    localparam int TEST_LEN     = 1 + 1 + 4 + 7 + 10 + 50;

    logic       clk;
    logic       reset;
    fetch_req_t req = '0;
    fetch_rsp_t rsp;
    wb_m2s_t    wb_out;
    wb_s2m_t    wb_in;
    int         read_count;

    int               errors       = 0;
    int               bus_errors   = 0;
    int               tests_run    = 0;
    int               tests_failed = 0;
    int               ack_count    = 0;
    logic [31:0]      lfsr         = 32'hcb00;
    fetch_line_addr_t reads[$];

    tb_clock_gen #(
        .PERIOD_NS    (CLK_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk (
        .clk   (clk),
        .reset (reset)
    );

    fetch_top #(
        .CACHE_DEPTH    (4),
        .PREFETCH_DEPTH (2)
    ) u_dut (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .rsp    (rsp),
        .wb_out (wb_out),
        .wb_in  (wb_in)
    );

    tb_inst_mem u_mem (
        .clk        (clk),
        .reset      (reset),
        .wb_out     (wb_out),
        .wb_in      (wb_in),
        .read_count (read_count)
    );

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rsp.ack) begin
            ack_count++;
        end
        if (wb_out.cyc && wb_out.stb && wb_in.ack) begin
            reads.push_back(wb_out.adr);
        end
        // instruction memory is read only
        if (!reset && wb_out.we !== 1'b0) begin
            bus_errors++;
            $display("ERR %0t: wb_out.we is %b, expected 0", $time, wb_out.we);
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // word n of memory with the byte offset dropped
    function automatic fetch_instr_t expect_instr(input fetch_pc_t pc);
        return fetch_instr_t'(pc.raw >> 2) ^ 32'h5a5a0000;
    endfunction

    task automatic check_instr(input string what, input fetch_instr_t got,
                               input fetch_instr_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s instr got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_line_addr(input string what, input fetch_line_addr_t got,
                                   input fetch_line_addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s line got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("ERR %0t: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%-14s ok", name);
        end else begin
            tests_failed++;
            $display("%-14s FAILED with %0d errors", name, errors - errs_before);
        end
    endtask

    // one request held until ack
    // starts and ends 1 ns after a rising edge
    task automatic fetch(input logic [31:0] addr, output fetch_instr_t instr,
                         output int cycles);
        int acks0;
        acks0       = ack_count;
        req.pc.raw  = addr;
        req.req     = 1'b1;
        cycles      = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (!rsp.ack);
        instr = rsp.instr;
        @(posedge clk);
        #1;
        req.req = 1'b0;
        @(posedge clk);
        #1;
        check_count("acks per request", ack_count - acks0, 1);
    endtask

    task automatic wait_bus_idle();
        int quiet;
        quiet = 0;
        while (quiet < 8) begin
            @(negedge clk);
            if (wb_out.cyc) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic reset_idle();
        int e0;
        e0 = errors;
        check_count("rsp.ack after reset", int'(rsp.ack), 0);
        check_count("cyc after reset", int'(wb_out.cyc), 0);
        check_count("stb after reset", int'(wb_out.stb), 0);
        repeat (20) @(posedge clk);
        #1;
        check_count("reads while idle", read_count, 0);
        check_count("acks while idle", ack_count, 0);
        report_test("reset_idle", e0);
    endtask

    task automatic cold_miss();
        int           e0;
        int           r0;
        int           cycles;
        fetch_instr_t instr;
        fetch_pc_t    pc;
        e0     = errors;
        r0     = reads.size();
        pc.raw = 32'h0000_1000;
        fetch(pc.raw, instr, cycles);
        check_instr("cold miss", instr, expect_instr(pc));
        if (reads.size() > r0) begin
            check_line_addr("first bus read", reads[r0], pc.fields.line);
        end else begin
            errors++;
            $display("cold miss was acked without any bus read");
        end
        report_test("cold_miss", e0);
    endtask

    task automatic repeat_hit();
        int           e0;
        int           rc0;
        int           cycles;
        fetch_instr_t instr;
        fetch_pc_t    pc;
        e0 = errors;
        wait_bus_idle();
        rc0    = read_count;
        pc.raw = 32'h0000_1004;
        for (int i = 0; i < 2; i++) begin
            fetch(pc.raw, instr, cycles);
            check_instr("hit", instr, expect_instr(pc));
            check_count("hit latency", cycles, 1);
        end
        check_count("reads during hits", read_count, rc0);
        report_test("hit", e0);
    endtask

    task automatic sequential_prefetch();
        int               e0;
        int               r0;
        int               cycles;
        fetch_instr_t     instr;
        fetch_pc_t        pc;
        fetch_line_addr_t m;
        e0 = errors;
        wait_bus_idle();
        r0     = reads.size();
        pc.raw = 32'h0004_0000;
        m      = pc.fields.line;
        fetch(pc.raw, instr, cycles);
        check_instr("miss before prefetch", instr, expect_instr(pc));
        wait_bus_idle();
        check_count("reads for miss and prefetch", reads.size() - r0, 3);
        if (reads.size() >= r0 + 3) begin
            for (int i = 0; i < 3; i++) begin
                check_line_addr("read order", reads[r0 + i], fetch_line_addr_t'(m + i));
            end
        end
        // word 0 of line m+1, word 1 of line m+2
        for (int i = 1; i <= 2; i++) begin
            pc.raw = 32'h0004_0000 + 32'(i * 8 + (i - 1) * 4);
            fetch(pc.raw, instr, cycles);
            check_instr("prefetched line", instr, expect_instr(pc));
            check_count("prefetched line latency", cycles, 1);
        end
        report_test("prefetch", e0);
    endtask

    task automatic line_replacement();
        int           e0;
        int           r0;
        int           cycles;
        fetch_instr_t instr;
        fetch_pc_t    pc;
        e0 = errors;
        wait_bus_idle();
        for (int i = 0; i < 5; i++) begin
            pc.raw = 32'h0010_0000 + 32'(i) * 32'h0001_0000;
            fetch(pc.raw, instr, cycles);
            check_instr("spread line", instr, expect_instr(pc));
        end
        wait_bus_idle();
        r0     = reads.size();
        pc.raw = 32'h0010_0000;
        fetch(pc.raw, instr, cycles);
        check_instr("evicted line", instr, expect_instr(pc));
        if (reads.size() > r0) begin
            check_line_addr("refetch of evicted line", reads[r0], pc.fields.line);
        end else begin
            errors++;
            $display("evicted line came back without a new bus read");
        end
        report_test("replace", e0);
    endtask

    task automatic random_pcs();
        int           e0;
        int           acks0;
        int           cycles;
        logic [31:0]  idx;
        fetch_instr_t instr;
        fetch_pc_t    pc;
        e0    = errors;
        acks0 = ack_count;
        for (int n = 0; n < 50; n++) begin
            draw_bits(8, idx);
            pc.raw = 32'h0002_0000 + (idx << 2);
            fetch(pc.raw, instr, cycles);
            check_instr("random pc", instr, expect_instr(pc));
        end
        check_count("acks for random pcs", ack_count - acks0, 50);
        report_test("random", e0);
    endtask

    initial begin
        #(CLK_NS * (RESET_CYCLES + TEST_LEN * MISS_LAT));
        $display("watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        wait (!reset);
        @(posedge clk);
        #1;
        reset_idle();
        cold_miss();
        repeat_hit();
        sequential_prefetch();
        line_replacement();
        random_pcs();
        errors += bus_errors;
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* list.f */
fetch_pkg.sv
wb_pkg.sv
fetch_line_cache.sv
fetch_mem_access.sv
fetch_next_addr.sv
fetch_top.sv
tb_clock_gen.sv
tb_inst_mem.sv
tb_fetch.sv

/* Makefile */
VERILATOR  := verilator
VFLAGS     := --binary --timing -j 0 --timescale 1ns/100ps
LINT_FLAGS := --lint-only --timing --timescale 1ns/100ps
TOP        := tb_fetch
FILELIST   := list.f
OBJ_DIR    := obj_dir
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
